// ==== fu_pkg.sv ====
package fu_pkg;

  // Datapath widths
  localparam int unsigned WORD_W = 64;
  localparam int unsigned TAG_W  = 6;

  typedef logic [WORD_W-1:0] word_t;  // Operand or result
  typedef logic [TAG_W-1:0]  tag_t;   // Physical register / ROB slot

  // Operation codes
  // ALU ops sit in 0..15 and MULQ at 16
  // Branches sit in 24..31, so the low three bits are the condition field
  typedef enum logic [4:0] {
    ALU_ADDQ   = 5'd0,
    ALU_SUBQ   = 5'd1,
    ALU_AND    = 5'd2,
    ALU_BIC    = 5'd3,
    ALU_BIS    = 5'd4,
    ALU_ORNOT  = 5'd5,
    ALU_XOR    = 5'd6,
    ALU_EQV    = 5'd7,
    ALU_SRL    = 5'd8,
    ALU_SLL    = 5'd9,
    ALU_SRA    = 5'd10,
    ALU_CMPULT = 5'd11,
    ALU_CMPEQ  = 5'd12,
    ALU_CMPULE = 5'd13,
    ALU_CMPLT  = 5'd14,
    ALU_CMPLE  = 5'd15,
    MUL_MULQ   = 5'd16,
    BR_BLBC    = 5'd24,  // Low bit clear
    BR_BEQ     = 5'd25,  // Zero
    BR_BLT     = 5'd26,  // Negative
    BR_BLE     = 5'd27,  // Zero or negative
    BR_BLBS    = 5'd28,  // Bit 2 set inverts the test
    BR_BNE     = 5'd29,
    BR_BGE     = 5'd30,
    BR_BGT     = 5'd31
  } fu_func_t;

  // Functional unit classes
  typedef enum logic [1:0] {
    CLASS_ALU  = 2'd0,
    CLASS_MULT = 2'd1,
    CLASS_BR   = 2'd2
  } fu_class_t;

  // Multiplier depth, 2, 4 or 8
  localparam int unsigned MULT_STAGES = 4;
  // Slice of B consumed per stage
  localparam int unsigned MULT_CHUNK  = WORD_W / MULT_STAGES;

  // Branch constants
  localparam int unsigned BR_DISP_W     = 21;
  localparam int unsigned BR_INSN_BYTES = 4;

endpackage

// ==== fu_issue_stage.sv ====
`timescale 1ns/1ps

module fu_issue_stage import fu_pkg::*; (
  input  logic                 clock,
  input  logic                 rst_n,
  input  logic                 issue_valid,
  input  fu_func_t             issue_func,
  input  tag_t                 issue_tag,
  input  word_t                issue_opa,
  input  word_t                issue_opb,
  input  word_t                issue_pc,
  input  logic [BR_DISP_W-1:0] issue_disp,
  input  logic                 issue_pred_taken,
  output logic                 alu_go,
  output logic                 mult_go,
  output logic                 br_go,
  output fu_func_t             op_func,
  output tag_t                 op_tag,
  output word_t                op_a,
  output word_t                op_b,
  output word_t                op_pc,
  output logic [BR_DISP_W-1:0] op_disp,
  output logic                 op_pred
);

  fu_class_t issue_class;

  // Map an operation code onto the unit that runs it
  function automatic fu_class_t op_class(input fu_func_t f);
    case (f)
      MUL_MULQ: return CLASS_MULT;
      BR_BLBC, BR_BEQ, BR_BLT, BR_BLE,
      BR_BLBS, BR_BNE, BR_BGE, BR_BGT: return CLASS_BR;
      default: return CLASS_ALU;
    endcase
  endfunction

  assign issue_class = op_class(issue_func);

  // One strobe per unit, low on idle cycles
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      alu_go  <= 1'b0;
      mult_go <= 1'b0;
      br_go   <= 1'b0;
    end else begin
      alu_go  <= issue_valid && (issue_class == CLASS_ALU);
      mult_go <= issue_valid && (issue_class == CLASS_MULT);
      br_go   <= issue_valid && (issue_class == CLASS_BR);
    end
  end

  // Shared operand fields, held between issues
  always_ff @(posedge clock) begin
    if (issue_valid) begin
      op_func <= issue_func;
      op_tag  <= issue_tag;
      op_a    <= issue_opa;
      op_b    <= issue_opb;
      op_pc   <= issue_pc;
      op_disp <= issue_disp;
      op_pred <= issue_pred_taken;
    end
  end

endmodule

// ==== fu_alu.sv ====
`timescale 1ns/1ps

module fu_alu import fu_pkg::*; (
  input  fu_func_t op_func,
  input  word_t    op_a,
  input  word_t    op_b,
  output word_t    alu_result
);

  logic [5:0] shamt;
  word_t      srl_val;
  word_t      sign_fill;
  logic       a_lt_b;      // Signed
  logic       a_ltu_b;     // Unsigned
  logic       a_eq_b;

  // Signed less-than, sign bits decide when they differ
  function automatic logic signed_lt(input word_t a, input word_t b);
    if (a[WORD_W-1] == b[WORD_W-1]) begin
      return a < b;          // Same sign, plain compare works
    end
    return a[WORD_W-1];      // Negative one is smaller
  endfunction

  assign shamt   = op_b[5:0];
  assign srl_val = op_a >> shamt;

  // Vacated upper bits for SRA
  assign sign_fill = op_a[WORD_W-1] ? ~({WORD_W{1'b1}} >> shamt) : '0;

  assign a_lt_b  = signed_lt(op_a, op_b);
  assign a_ltu_b = op_a < op_b;
  assign a_eq_b  = op_a == op_b;

  always_comb begin
    case (op_func)
      ALU_ADDQ:   alu_result = op_a + op_b;
      ALU_SUBQ:   alu_result = op_a - op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_BIC:    alu_result = op_a & ~op_b;
      ALU_BIS:    alu_result = op_a | op_b;
      ALU_ORNOT:  alu_result = op_a | ~op_b;
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_EQV:    alu_result = op_a ^ ~op_b;
      ALU_SRL:    alu_result = srl_val;
      ALU_SLL:    alu_result = op_a << shamt;
      ALU_SRA:    alu_result = srl_val | sign_fill;
      ALU_CMPULT: alu_result = word_t'(a_ltu_b);
      ALU_CMPEQ:  alu_result = word_t'(a_eq_b);
      ALU_CMPULE: alu_result = word_t'(a_ltu_b || a_eq_b);
      ALU_CMPLT:  alu_result = word_t'(a_lt_b);
      ALU_CMPLE:  alu_result = word_t'(a_lt_b || a_eq_b);
      default:    alu_result = '0;  // MULQ and branches
    endcase
  end

endmodule

// ==== fu_brcond.sv ====
`timescale 1ns/1ps

module fu_brcond import fu_pkg::*; (
  input  fu_func_t             op_func,
  input  word_t                op_a,
  input  word_t                op_pc,
  input  logic [BR_DISP_W-1:0] op_disp,
  input  logic                 op_pred,
  output logic                 br_taken_c,
  output word_t                br_target_c,
  output logic                 br_mispredict_c
);

  logic  cond_raw;
  logic  a_zero;
  logic  a_neg;
  word_t disp_off;

  assign a_zero = (op_a == '0);
  assign a_neg  = op_a[WORD_W-1];

  // Base test from the two low condition bits
  always_comb begin
    case (op_func[1:0])
      2'b00:   cond_raw = ~op_a[0];         // LBC
      2'b01:   cond_raw = a_zero;           // EQ
      2'b10:   cond_raw = a_neg;            // LT
      default: cond_raw = a_neg | a_zero;   // LE
    endcase
  end

  // Bit 2 flips the sense
  assign br_taken_c = cond_raw ^ op_func[2];

  // Word displacement, sign extended and scaled to bytes
  assign disp_off = {{(WORD_W-BR_DISP_W-2){op_disp[BR_DISP_W-1]}}, op_disp, 2'b00};

  assign br_target_c = op_pc + word_t'(BR_INSN_BYTES) + disp_off;

  assign br_mispredict_c = br_taken_c != op_pred;

endmodule

// ==== fu_mult.sv ====
`timescale 1ns/1ps

module fu_mult import fu_pkg::*; (
  input  logic  clock,
  input  logic  rst_n,
  input  logic  mult_go,
  input  tag_t  op_tag,
  input  word_t op_a,
  input  word_t op_b,
  output logic  mult_out_valid,
  output tag_t  mult_out_tag,
  output word_t mult_out_result
);

  // Per-stage state, one multiply per stage
  logic  valid_q [MULT_STAGES];
  tag_t  tag_q   [MULT_STAGES];
  word_t psum_q  [MULT_STAGES];   // Running partial product
  // Operands still to be consumed, not needed after the last stage
  word_t a_q     [MULT_STAGES-1];
  word_t b_q     [MULT_STAGES-1];

  for (genvar s = 0; s < MULT_STAGES; s++) begin : g_stage
    logic  v_in;
    tag_t  t_in;
    word_t p_in;
    word_t a_in;
    word_t b_in;

    if (s == 0) begin : g_first
      assign v_in = mult_go;
      assign t_in = op_tag;
      assign p_in = '0;
      assign a_in = op_a;
      assign b_in = op_b;
    end else begin : g_next
      assign v_in = valid_q[s-1];
      assign t_in = tag_q[s-1];
      assign p_in = psum_q[s-1];
      assign a_in = a_q[s-1];
      assign b_in = b_q[s-1];
    end

    always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
        valid_q[s] <= 1'b0;
      end else begin
        valid_q[s] <= v_in;
      end
    end

    // A already shifted into place, so only the low slice of B counts
    always_ff @(posedge clock) begin
      if (v_in) begin
        tag_q[s]  <= t_in;
        psum_q[s] <= p_in + a_in * word_t'(b_in[MULT_CHUNK-1:0]);
      end
    end

    if (s < MULT_STAGES - 1) begin : g_pass
      always_ff @(posedge clock) begin
        if (v_in) begin
          a_q[s] <= a_in << MULT_CHUNK;   // Weight of next slice
          b_q[s] <= b_in >> MULT_CHUNK;   // Drop consumed slice
        end
      end
    end
  end

  // Low 64 bits only, same for signed and unsigned
  assign mult_out_valid  = valid_q[MULT_STAGES-1];
  assign mult_out_tag    = tag_q[MULT_STAGES-1];
  assign mult_out_result = psum_q[MULT_STAGES-1];

endmodule

// ==== fu_complete_stage.sv ====
`timescale 1ns/1ps

module fu_complete_stage import fu_pkg::*; (
  input  logic  clock,
  input  logic  rst_n,
  input  logic  alu_go,
  input  logic  br_go,
  input  tag_t  op_tag,
  input  word_t alu_result,
  input  logic  br_taken_c,
  input  word_t br_target_c,
  input  logic  br_mispredict_c,
  input  logic  mult_out_valid,
  input  tag_t  mult_out_tag,
  input  word_t mult_out_result,
  output logic  alu_done,
  output tag_t  alu_tag,
  output word_t alu_result_q,
  output logic  mult_done,
  output tag_t  mult_tag,
  output word_t mult_result_q,
  output logic  br_done,
  output tag_t  br_tag,
  output logic  br_taken,
  output word_t br_target,
  output logic  br_mispredict
);

  // Done pulses, one cycle per strobe
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      alu_done  <= 1'b0;
      mult_done <= 1'b0;
      br_done   <= 1'b0;
    end else begin
      alu_done  <= alu_go;
      mult_done <= mult_out_valid;
      br_done   <= br_go;
    end
  end

  // ALU writeback
  always_ff @(posedge clock) begin
    if (alu_go) begin
      alu_tag      <= op_tag;
      alu_result_q <= alu_result;
    end
  end

  // Multiplier writeback, tag comes down the pipe
  always_ff @(posedge clock) begin
    if (mult_out_valid) begin
      mult_tag      <= mult_out_tag;
      mult_result_q <= mult_out_result;
    end
  end

  // Branch resolution
  always_ff @(posedge clock) begin
    if (br_go) begin
      br_tag        <= op_tag;
      br_taken      <= br_taken_c;
      br_target     <= br_target_c;
      br_mispredict <= br_mispredict_c;
    end
  end

endmodule

// ==== fu_exec_top.sv ====
`timescale 1ns/1ps

module fu_exec_top import fu_pkg::*; (
  input  logic                 clock,
  input  logic                 rst_n,
  input  logic                 issue_valid,
  input  fu_func_t             issue_func,
  input  tag_t                 issue_tag,
  input  word_t                issue_opa,
  input  word_t                issue_opb,
  input  word_t                issue_pc,
  input  logic [BR_DISP_W-1:0] issue_disp,
  input  logic                 issue_pred_taken,
  output logic                 alu_done,
  output tag_t                 alu_tag,
  output word_t                alu_result,
  output logic                 mult_done,
  output tag_t                 mult_tag,
  output word_t                mult_result,
  output logic                 br_done,
  output tag_t                 br_tag,
  output logic                 br_taken,
  output word_t                br_target,
  output logic                 br_mispredict
);

  logic                 alu_go;
  logic                 mult_go;
  logic                 br_go;
  fu_func_t             op_func;
  tag_t                 op_tag;
  word_t                op_a;
  word_t                op_b;
  word_t                op_pc;
  logic [BR_DISP_W-1:0] op_disp;
  logic                 op_pred;
  word_t                alu_result_c;     // Unregistered ALU output
  logic                 br_taken_c;
  word_t                br_target_c;
  logic                 br_mispredict_c;
  logic                 mult_out_valid;
  tag_t                 mult_out_tag;
  word_t                mult_out_result;

  fu_issue_stage i_issue (
    .clock, .rst_n, .issue_valid, .issue_func, .issue_tag, .issue_opa, .issue_opb,
    .issue_pc, .issue_disp, .issue_pred_taken, .alu_go, .mult_go, .br_go,
    .op_func, .op_tag, .op_a, .op_b, .op_pc, .op_disp, .op_pred
  );

  fu_alu i_alu (.op_func, .op_a, .op_b, .alu_result(alu_result_c));

  fu_brcond i_brcond (
    .op_func, .op_a, .op_pc, .op_disp, .op_pred,
    .br_taken_c, .br_target_c, .br_mispredict_c
  );

  fu_mult i_mult (
    .clock, .rst_n, .mult_go, .op_tag, .op_a, .op_b,
    .mult_out_valid, .mult_out_tag, .mult_out_result
  );

  fu_complete_stage i_complete (
    .clock, .rst_n, .alu_go, .br_go, .op_tag,
    .alu_result(alu_result_c), .br_taken_c, .br_target_c, .br_mispredict_c,
    .mult_out_valid, .mult_out_tag, .mult_out_result,
    .alu_done, .alu_tag, .alu_result_q(alu_result),
    .mult_done, .mult_tag, .mult_result_q(mult_result),
    .br_done, .br_tag, .br_taken, .br_target, .br_mispredict
  );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 2,   // 4 ns clock
  parameter int RESET_CYCLES = 16
) (
  output logic clock,
  output logic rst_n
);

  initial begin
    clock = 1'b0;
    forever #HALF_PERIOD clock = ~clock;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    rst_n = 1'b1;
  end

endmodule

// ==== tb_fu_exec.sv ====
`timescale 1ns/1ps

module tb_fu_exec import fu_pkg::*; ();

  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned ALU_ROUNDS   = 6;    // Per ALU code
  localparam int unsigned MUL_BURST    = 24;
  localparam int unsigned BR_ROUNDS    = 6;    // Per branch condition
  localparam int unsigned MIX_OPS      = 60;
  localparam int unsigned TOTAL_OPS    = 16 * ALU_ROUNDS + MUL_BURST + 8 * BR_ROUNDS
                                         + 1 + MULT_STAGES + MIX_OPS;
  localparam int unsigned TIMEOUT_CYCLES = RESET_CYCLES + TOTAL_OPS + MULT_STAGES + 50;

  typedef struct packed {
    logic [31:0] due;    // Cycle count when done is expected
    tag_t        tag;
    word_t       value;
  } wb_exp_t;

  typedef struct packed {
    logic [31:0] due;
    tag_t        tag;
    logic        taken;
    word_t       target;
    logic        mispredict;
  } br_exp_t;

  logic                 clock;
  logic                 rst_n;
  logic                 issue_valid;
  fu_func_t             issue_func;
  tag_t                 issue_tag;
  word_t                issue_opa;
  word_t                issue_opb;
  word_t                issue_pc;
  logic [BR_DISP_W-1:0] issue_disp;
  logic                 issue_pred_taken;
  logic                 alu_done;
  tag_t                 alu_tag;
  word_t                alu_result;
  logic                 mult_done;
  tag_t                 mult_tag;
  word_t                mult_result;
  logic                 br_done;
  tag_t                 br_tag;
  logic                 br_taken;
  word_t                br_target;
  logic                 br_mispredict;

  wb_exp_t     alu_q[$];
  wb_exp_t     mult_q[$];
  br_exp_t     br_q[$];
  int unsigned cycle = 0;
  int unsigned overlap_cnt = 0;   // ALU and multiply done together
  tag_t        next_tag;

  tb_clock_gen #(.HALF_PERIOD(2), .RESET_CYCLES(RESET_CYCLES)) i_clk (.clock, .rst_n);

  fu_exec_top i_dut (
    .clock, .rst_n, .issue_valid, .issue_func, .issue_tag, .issue_opa, .issue_opb,
    .issue_pc, .issue_disp, .issue_pred_taken,
    .alu_done, .alu_tag, .alu_result, .mult_done, .mult_tag, .mult_result,
    .br_done, .br_tag, .br_taken, .br_target, .br_mispredict
  );

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else
      report_failure($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
                               $time, name, got, exp));
  endtask

  function automatic fu_class_t class_of(input fu_func_t f);
    if (f == MUL_MULQ) return CLASS_MULT;
    if (f >= BR_BLBC) return CLASS_BR;
    return CLASS_ALU;
  endfunction

  // Reference ALU built on signed operators
  function automatic word_t alu_expect(input fu_func_t f, input word_t a, input word_t b);
    int unsigned sh;
    sh = b[5:0];
    case (f)
      ALU_ADDQ:   return a + b;
      ALU_SUBQ:   return a - b;
      ALU_AND:    return a & b;
      ALU_BIC:    return a & ~b;
      ALU_BIS:    return a | b;
      ALU_ORNOT:  return a | ~b;
      ALU_XOR:    return a ^ b;
      ALU_EQV:    return ~(a ^ b);
      ALU_SRL:    return a >> sh;
      ALU_SLL:    return a << sh;
      ALU_SRA:    return $signed(a) >>> sh;
      ALU_CMPULT: return word_t'(a < b);
      ALU_CMPEQ:  return word_t'(a == b);
      ALU_CMPULE: return word_t'(a <= b);
      ALU_CMPLT:  return word_t'($signed(a) < $signed(b));
      ALU_CMPLE:  return word_t'($signed(a) <= $signed(b));
      default:    return '0;
    endcase
  endfunction

  function automatic logic taken_expect(input fu_func_t f, input word_t a);
    case (f)
      BR_BLBC: return !a[0];
      BR_BEQ:  return a == '0;
      BR_BLT:  return $signed(a) < 0;
      BR_BLE:  return $signed(a) <= 0;
      BR_BLBS: return a[0];
      BR_BNE:  return a != '0;
      BR_BGE:  return $signed(a) >= 0;
      BR_BGT:  return $signed(a) > 0;
      default: return 1'b0;
    endcase
  endfunction

  function automatic word_t target_expect(input word_t pc, input logic [BR_DISP_W-1:0] disp);
    logic signed [63:0] offset;
    offset = $signed(disp);   // Sign extension
    return pc + 64'd4 + offset * 4;
  endfunction

  function automatic word_t pick_operand();
    case ($urandom % 8)
      0:       return '0;
      1:       return '1;
      2:       return {1'b1, 63'b0};  // Most negative
      3:       return 64'd63;         // Largest shift amount
      default: return {$urandom, $urandom};
    endcase
  endfunction

  function automatic word_t pick_branch_operand(input int kind);
    word_t r;
    r = {$urandom, $urandom};
    case (kind)
      0:       return '0;
      1:       return {1'b0, r[62:1], 1'b0};  // Positive even
      2:       return {1'b0, r[62:1], 1'b1};  // Positive odd
      3:       return {1'b1, r[62:0]};        // Negative
      default: return '1;
    endcase
  endfunction

  // Drive one operation and queue what its port should return
  task automatic issue_op(input fu_func_t f, input word_t a, input word_t b,
                          input word_t pc, input logic [BR_DISP_W-1:0] disp,
                          input logic pred);
    wb_exp_t w;
    br_exp_t e;
    @(negedge clock);
    issue_valid      = 1'b1;
    issue_func       = f;
    issue_tag        = next_tag;
    issue_opa        = a;
    issue_opb        = b;
    issue_pc         = pc;
    issue_disp       = disp;
    issue_pred_taken = pred;
    case (class_of(f))
      CLASS_MULT: begin
        w.due   = cycle + 2 + MULT_STAGES;
        w.tag   = next_tag;
        w.value = a * b;   // Low 64 bits
        mult_q.push_back(w);
      end
      CLASS_BR: begin
        e.due        = cycle + 2;
        e.tag        = next_tag;
        e.taken      = taken_expect(f, a);
        e.target     = target_expect(pc, disp);
        e.mispredict = e.taken ^ pred;
        br_q.push_back(e);
      end
      default: begin
        w.due   = cycle + 2;
        w.tag   = next_tag;
        w.value = alu_expect(f, a, b);
        alu_q.push_back(w);
      end
    endcase
    next_tag++;
  endtask

  always @(posedge clock) begin
    cycle = cycle + 1;
    if (cycle >= TIMEOUT_CYCLES)
      report_failure($sformatf("Timeout after %0d cycles, run did not finish", cycle));
  end

  // Outputs are stable at the falling edge
  always @(negedge clock) begin : scoreboard
    wb_exp_t w;
    br_exp_t e;
    if (!rst_n) begin
      check_value("alu_done", alu_done, 0);
      check_value("mult_done", mult_done, 0);
      check_value("br_done", br_done, 0);
    end else begin
      if (alu_done && mult_done) overlap_cnt++;
      if (alu_done) begin
        if (alu_q.size() == 0) report_failure("alu_done pulsed with no ALU result pending");
        else begin
          w = alu_q.pop_front();
          check_value("alu_done cycle", cycle, w.due);
          check_value("alu_tag", alu_tag, w.tag);
          check_value("alu_result", alu_result, w.value);
        end
      end else if (alu_q.size() != 0 && alu_q[0].due == cycle) begin
        report_failure("alu_done missing for a pending ALU result");
      end
      if (mult_done) begin
        if (mult_q.size() == 0) report_failure("mult_done pulsed with no product pending");
        else begin
          w = mult_q.pop_front();
          check_value("mult_done cycle", cycle, w.due);
          check_value("mult_tag", mult_tag, w.tag);
          check_value("mult_result", mult_result, w.value);
        end
      end else if (mult_q.size() != 0 && mult_q[0].due == cycle) begin
        report_failure("mult_done missing for a pending product");
      end
      if (br_done) begin
        if (br_q.size() == 0) report_failure("br_done pulsed with no branch pending");
        else begin
          e = br_q.pop_front();
          check_value("br_done cycle", cycle, e.due);
          check_value("br_tag", br_tag, e.tag);
          check_value("br_taken", br_taken, e.taken);
          check_value("br_target", br_target, e.target);
          check_value("br_mispredict", br_mispredict, e.mispredict);
        end
      end else if (br_q.size() != 0 && br_q[0].due == cycle) begin
        report_failure("br_done missing for a pending branch");
      end
    end
  end

  initial begin
    word_t    a;
    word_t    b;
    fu_func_t f;
    void'($urandom(32'hbacfe3a8));
    issue_valid      = 1'b0;
    issue_func       = ALU_ADDQ;
    issue_tag        = '0;
    issue_opa        = '0;
    issue_opb        = '0;
    issue_pc         = '0;
    issue_disp       = '0;
    issue_pred_taken = 1'b0;
    next_tag         = '0;

    @(posedge rst_n);
    @(negedge clock);
    check_value("alu_done", alu_done, 0);   // First cycle out of reset
    check_value("mult_done", mult_done, 0);
    check_value("br_done", br_done, 0);

    // Every ALU code, sign-crossing and shift corners first
    for (int k = 0; k < 16; k++) begin
      for (int r = 0; r < ALU_ROUNDS; r++) begin
        case (r)
          0:       begin a = -64'sd5;        b = 64'd3;     end
          1:       begin a = 64'd3;          b = -64'sd5;   end
          2:       begin a = {1'b1, 63'b0};  b = 64'd63;    end
          3:       begin a = '1;             b = '0;        end
          default: begin a = pick_operand(); b = pick_operand(); end
        endcase
        issue_op(fu_func_t'(k), a, b, '0, '0, 1'b0);
      end
    end

    repeat (MUL_BURST) issue_op(MUL_MULQ, pick_operand(), pick_operand(), '0, '0, 1'b0);

    for (int k = 0; k < 8; k++) begin
      for (int r = 0; r < BR_ROUNDS; r++) begin
        issue_op(fu_func_t'(BR_BLBC + k), pick_branch_operand(r < 5 ? r : $urandom % 5),
                 '0, {$urandom, $urandom} & ~64'd3, BR_DISP_W'($urandom), 1'($urandom));
      end
    end

    // Last ALU op here finishes with the multiply
    issue_op(MUL_MULQ, pick_operand(), pick_operand(), '0, '0, 1'b0);
    repeat (MULT_STAGES) issue_op(fu_func_t'($urandom % 16), pick_operand(), pick_operand(),
                                  '0, '0, 1'b0);
    repeat (MIX_OPS) begin
      case ($urandom % 3)
        0:       f = fu_func_t'($urandom % 16);
        1:       f = MUL_MULQ;
        default: f = fu_func_t'(BR_BLBC + $urandom % 8);
      endcase
      issue_op(f, pick_operand(), pick_operand(), {$urandom, $urandom} & ~64'd3,
               BR_DISP_W'($urandom), 1'($urandom));
    end

    @(negedge clock);
    issue_valid = 1'b0;
    repeat (MULT_STAGES + 4) @(negedge clock);

    if (alu_q.size() == 0 && mult_q.size() == 0 && br_q.size() == 0 && overlap_cnt != 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      report_failure("Results still pending at the end, or no ALU and multiply overlap seen");
    end
  end

endmodule

// ==== sources.f ====
fu_pkg.sv
fu_issue_stage.sv
fu_alu.sv
fu_brcond.sv
fu_mult.sv
fu_complete_stage.sv
fu_exec_top.sv
tb_clock_gen.sv
tb_fu_exec.sv

// ==== Bender.yml ====
package:
  name: fu_exec

sources:
  - fu_pkg.sv
  - fu_issue_stage.sv
  - fu_alu.sv
  - fu_brcond.sv
  - fu_mult.sv
  - fu_complete_stage.sv
  - fu_exec_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_fu_exec.sv
